// File: bench/plot_checker.sv
`timescale 1ns/1ps
`include "scene_consts.svh"

module plot_checker (
	input  logic                    clock,
	input  logic                    reset_n,
	input  logic                    draw_start,
	input  scene_pkg::coord_x_t     enemy_x,
	input  logic                    sprite_we,
	input  scene_pkg::sprite_addr_t sprite_waddr,
	input  scene_pkg::colour_t      sprite_wdata,
	input  logic                    plot,
	input  scene_pkg::coord_x_t     plot_x,
	input  scene_pkg::coord_y_t     plot_y,
	input  scene_pkg::colour_t      plot_colour,
	input  logic                    scene_done,
	input  logic                    busy,
	output int                      tests_run,
	output int                      tests_failed,
	output int                      error_count
);
	import scene_pkg::*;

	// a sprite takes its pixels plus one idle cycle
	localparam int SPRITE_SLOT = `SPRITE_PIXELS + 1;
	// plot rises on the third edge after the start edge, seen on the fourth
	localparam int FIRST_PLOT = 4;

	colour_t shadow [0:`SPRITE_PIXELS-1];
	coord_x_t exp_x [$];
	coord_y_t exp_y [$];
	colour_t exp_c [$];
	int exp_t [$];
	logic init_next;
	logic scene_init;
	logic in_scene;
	logic done_seen;
	logic in_reset;
	int cyc;
	int start_cyc;
	int idx;
	int scene_num;
	int test_errs;

	// expected plots of one scene, sprites in list order, pixels row by row
	function automatic void build_expected(input logic init_scene, input coord_x_t ex);
		int bx [4];
		int count;
		int p;
		exp_x.delete();
		exp_y.delete();
		exp_c.delete();
		exp_t.delete();
		if (init_scene)
		begin
			bx[0] = `INIT_ENEMY_X;
			bx[1] = `INIT_LEFT_X;
			bx[2] = `INIT_PLAYER_X;
			bx[3] = `INIT_RIGHT_X;
			count = 4;
		end
		else
		begin
			// no player in the update scene
			bx[0] = ex;
			bx[1] = `UPD_LEFT_X;
			bx[2] = `UPD_RIGHT_X;
			bx[3] = 0;
			count = 3;
		end
		for (int s = 0; s < count; s++)
			for (int r = 0; r < `SPRITE_DIM; r++)
				for (int c = 0; c < `SPRITE_DIM; c++)
				begin
					p = r * `SPRITE_DIM + c;
					exp_x.push_back(coord_x_t'((bx[s] + c) % 256));
					exp_y.push_back(coord_y_t'((s == 0 ? `ENEMY_Y : `HAND_ROW_Y) + r));
					exp_c.push_back(shadow[p]);
					exp_t.push_back(FIRST_PLOT + s * SPRITE_SLOT + p);
				end
	endfunction

	task automatic flag_error(input string msg);
		test_errs++;
		error_count++;
		if (test_errs <= 10)
			$display("[ERROR] %0t: %s", $time, msg);
	endtask

	task automatic compare_field(input string what, input logic [31:0] got,
		input logic [31:0] want);
		if (got !== want)
			flag_error($sformatf("scene %0d plot %0d %s is %0d, expected %0d",
				scene_num, idx, what, got, want));
	endtask

	task automatic close_test(input string name);
		tests_run++;
		if (test_errs != 0)
			tests_failed++;
		$display("test %0d, %s: %0d errors", tests_run, name, test_errs);
		test_errs = 0;
	endtask

	initial
	begin
		tests_run = 0;
		tests_failed = 0;
		error_count = 0;
		test_errs = 0;
		cyc = 0;
		scene_num = 0;
		idx = 0;
		in_scene = 1'b0;
		in_reset = 1'b0;
		init_next = 1'b1;
	end

	always @(posedge clock)
	begin
		cyc++;
		if (sprite_we === 1'b1)
		begin
			shadow[sprite_waddr] = sprite_wdata;
			if (busy === 1'b1)
				flag_error("sprite memory written while busy");
		end
		if (reset_n !== 1'b1)
		begin
			if (!in_reset && in_scene)
				close_test($sformatf("scene %0d cut by reset after %0d plots", scene_num, idx));
			else if (in_reset && (plot !== 1'b0 || busy !== 1'b0 || scene_done !== 1'b0))
				flag_error("outputs not low during reset");
			if (!in_reset)
				test_errs = 0;
			in_scene = 1'b0;
			in_reset = 1'b1;
			init_next = 1'b1;
		end
		else if (in_reset)
		begin
			if (plot !== 1'b0 || busy !== 1'b0 || scene_done !== 1'b0)
				flag_error("outputs not low after reset");
			close_test("reset clears plot, busy and scene_done");
			in_reset = 1'b0;
		end
		else if (!in_scene)
		begin
			if (draw_start === 1'b1 && busy === 1'b0)
			begin
				build_expected(init_next, enemy_x);
				scene_init = init_next;
				scene_num++;
				start_cyc = cyc;
				idx = 0;
				done_seen = 1'b0;
				in_scene = 1'b1;
				test_errs = 0;
			end
			else if (plot !== 1'b0 || scene_done !== 1'b0)
				flag_error("plot or scene_done while no scene is drawn");
		end
		else if (done_seen)
		begin
			if (busy !== 1'b0)
				flag_error("busy still high one cycle after scene_done");
			if (plot !== 1'b0)
				flag_error("plot after the last pixel of the scene");
			close_test($sformatf("scene %0d, %s, %0d plots", scene_num,
				scene_init ? "initial" : "update", idx));
			in_scene = 1'b0;
			init_next = 1'b0;
		end
		else
		begin
			if (busy !== 1'b1)
				flag_error("busy low while the scene is drawn");
			if (plot === 1'b1)
			begin
				if (idx >= exp_x.size())
					flag_error("more plots than the scene has");
				else
				begin
					compare_field("cycle", cyc - start_cyc, exp_t[idx]);
					compare_field("x", plot_x, exp_x[idx]);
					compare_field("y", plot_y, exp_y[idx]);
					compare_field("colour", plot_colour, exp_c[idx]);
					compare_field("scene_done", scene_done, idx == exp_x.size() - 1);
				end
				idx++;
			end
			else if (scene_done !== 1'b0)
				flag_error("scene_done without plot");
			if (scene_done === 1'b1)
				done_seen = 1'b1;
		end
	end

endmodule

// File: bench/scene_plotter_tb.sv
`timescale 1ns/1ps
`include "scene_consts.svh"

module scene_plotter_tb;
	import scene_pkg::*;

	localparam int CLOCK_PERIOD = 40;
	localparam int RESET_CYCLES = 8;
	// pixels of the five scenes, the cut one counted in full
	localparam int RUN_PIXELS = 6400 + 4800 + 4800 + 4800 + 6400;
	localparam int WATCHDOG_CYCLES = RUN_PIXELS * 3 / 2 + 2 * `SPRITE_PIXELS + 1000;
	localparam int SCENE_LIMIT = 4 * (`SPRITE_PIXELS + 1) + 20;
	// two reset checks and five scenes
	localparam int TEST_COUNT = 7;

	logic clock;
	logic reset_n;
	logic draw_start;
	coord_x_t enemy_x;
	logic sprite_we;
	sprite_addr_t sprite_waddr;
	colour_t sprite_wdata;
	logic plot;
	coord_x_t plot_x;
	coord_y_t plot_y;
	colour_t plot_colour;
	logic scene_done;
	logic busy;
	int tests_run;
	int tests_failed;
	int error_count;
	int bench_errors;
	logic [31:0] lfsr;

	scene_plotter scene_plotter_i (.*);

	plot_checker plot_checker_i (.*);

	initial
	begin
		clock = 1'b0;
		forever
			#(CLOCK_PERIOD / 2) clock = ~clock;
	end

	// taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v = {v[30:0], lfsr[0]};
		end
		return v;
	endfunction

	task automatic load_image();
		for (int a = 0; a < `SPRITE_PIXELS; a++)
		begin
			@(negedge clock);
			sprite_we = 1'b1;
			sprite_waddr = sprite_addr_t'(a);
			sprite_wdata = colour_t'(random_bits(3));
		end
		@(negedge clock);
		sprite_we = 1'b0;
	endtask

	task automatic pulse_draw(input logic [31:0] ex);
		@(negedge clock);
		enemy_x = coord_x_t'(ex);
		draw_start = 1'b1;
		@(negedge clock);
		draw_start = 1'b0;
	endtask

	task automatic wait_scene_done();
		int n;
		n = 0;
		while (scene_done !== 1'b1 && n < SCENE_LIMIT)
		begin
			@(negedge clock);
			n++;
		end
		if (scene_done !== 1'b1)
		begin
			$display("scene_done did not arrive within %0d cycles", SCENE_LIMIT);
			bench_errors++;
		end
		// busy drops one cycle later
		repeat (3) @(negedge clock);
	endtask

	task automatic apply_reset();
		@(negedge clock);
		reset_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clock);
		reset_n = 1'b1;
	endtask

	initial
	begin
		lfsr = 32'hae4f_6a8a;
		bench_errors = 0;
		reset_n = 1'b0;
		draw_start = 1'b0;
		enemy_x = '0;
		sprite_we = 1'b0;
		sprite_waddr = '0;
		sprite_wdata = '0;
		repeat (RESET_CYCLES) @(negedge clock);
		reset_n = 1'b1;

		// initial scene, enemy_x has no effect here
		load_image();
		pulse_draw(random_bits(8));
		wait_scene_done();

		// update scene with the enemy wrapping past x = 255
		pulse_draw(217 + random_bits(5));
		wait_scene_done();

		// stray requests while busy, one near the first sprite boundary
		pulse_draw(random_bits(8));
		repeat (1599) @(negedge clock);
		pulse_draw(random_bits(8));
		repeat (2000) @(negedge clock);
		pulse_draw(random_bits(8));
		wait_scene_done();

		// reset in the middle of a scene, then a fresh image
		pulse_draw(random_bits(8));
		repeat (1000) @(negedge clock);
		apply_reset();
		load_image();
		pulse_draw(random_bits(8));
		wait_scene_done();

		repeat (4) @(negedge clock);
		$display("tests run %0d, failed %0d, plot errors %0d, bench errors %0d",
			tests_run, tests_failed, error_count, bench_errors);
		if (tests_run == TEST_COUNT && tests_failed == 0 && error_count == 0 && bench_errors == 0)
			$display("TEST RESULT: PASS");
		else
			$display("TEST RESULT: FAIL");
		$finish;
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clock);
		$display("watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$finish;
	end

endmodule

// File: files.f
+incdir+src
src/scene_pkg.sv
src/scene_sequencer.sv
src/sprite_scanner.sv
src/sprite_rom.sv
src/plot_stage.sv
src/scene_plotter.sv
bench/plot_checker.sv
bench/scene_plotter_tb.sv

// File: src/plot_stage.sv
`timescale 1ns/1ps

module plot_stage (
	input  logic                clock,
	input  logic                reset_n,
	input  logic                pix_valid,
	input  scene_pkg::coord_x_t pix_x,
	input  scene_pkg::coord_y_t pix_y,
	input  logic                pix_last,
	input  scene_pkg::colour_t  rd_colour,
	output logic                plot,
	output scene_pkg::coord_x_t plot_x,
	output scene_pkg::coord_y_t plot_y,
	output scene_pkg::colour_t  plot_colour,
	output logic                scene_done
);
	import scene_pkg::*;

	// coordinates delayed to meet the memory data
	logic al_valid;
	logic al_last;
	coord_x_t al_x;
	coord_y_t al_y;

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			al_valid <= 1'b0;
			al_last <= 1'b0;
			plot <= 1'b0;
			scene_done <= 1'b0;
		end
		else
		begin
			al_valid <= pix_valid;
			al_last <= pix_last;
			plot <= al_valid;
			scene_done <= al_last;
		end
	end

	always_ff @(posedge clock)
	begin
		al_x <= pix_x;
		al_y <= pix_y;
		plot_x <= al_x;
		plot_y <= al_y;
		plot_colour <= rd_colour;
	end

	a_done_with_plot: assert property (@(posedge clock) disable iff (!reset_n)
		scene_done |-> plot);

endmodule

// File: src/scene_consts.svh
`ifndef SCENE_CONSTS_SVH
`define SCENE_CONSTS_SVH

// screen coordinate and colour widths, 160x120 at 3 bits
`define X_W 8
`define Y_W 7
`define COLOUR_W 3

// sprite geometry, one shared 40x40 image
`define SPRITE_DIM 40
`define SPRITE_PIXELS 1600
`define ADDR_W 11

// fixed rows
`define ENEMY_Y 6
`define HAND_ROW_Y 70

// x bases of the initial scene
`define INIT_ENEMY_X 12
`define INIT_LEFT_X 0
`define INIT_PLAYER_X 40
`define INIT_RIGHT_X 80

// x bases of the update scene, enemy x comes from the port
`define UPD_LEFT_X 20
`define UPD_RIGHT_X 100

`endif

// File: src/scene_pkg.sv
`include "scene_consts.svh"

package scene_pkg;

	// screen coordinates, x wraps at 256
	typedef logic [`X_W-1:0] coord_x_t;
	typedef logic [`Y_W-1:0] coord_y_t;

	// 3-bit rgb pixel
	typedef logic [`COLOUR_W-1:0] colour_t;

	// word address into the sprite image
	typedef logic [`ADDR_W-1:0] sprite_addr_t;

	// sprites in drawing order of the initial scene
	typedef enum logic [1:0] {
		ENEMY,
		LEFT_HAND,
		PLAYER,
		RIGHT_HAND
	} sprite_id_t;

endpackage

// File: src/scene_plotter.sv
`timescale 1ns/1ps

module scene_plotter (
	input  logic                    clock,
	input  logic                    reset_n,
	input  logic                    draw_start,
	input  scene_pkg::coord_x_t     enemy_x,
	input  logic                    sprite_we,
	input  scene_pkg::sprite_addr_t sprite_waddr,
	input  scene_pkg::colour_t      sprite_wdata,
	output logic                    plot,
	output scene_pkg::coord_x_t     plot_x,
	output scene_pkg::coord_y_t     plot_y,
	output scene_pkg::colour_t      plot_colour,
	output logic                    scene_done,
	output logic                    busy
);
	import scene_pkg::*;

	// sequencer to scanner
	logic sprite_go;
	coord_x_t base_x;
	coord_y_t base_y;
	logic scene_last;
	logic sprite_end;

	// scanner to memory and plot stage
	logic pix_valid;
	sprite_addr_t addr;
	coord_x_t pix_x;
	coord_y_t pix_y;
	logic pix_last;
	colour_t rd_colour;

	scene_sequencer u_sequencer (
		.clock      (clock),
		.reset_n    (reset_n),
		.draw_start (draw_start),
		.enemy_x    (enemy_x),
		.sprite_end (sprite_end),
		.sprite_go  (sprite_go),
		.base_x     (base_x),
		.base_y     (base_y),
		.scene_last (scene_last),
		.busy       (busy)
	);

	sprite_scanner u_scanner (
		.clock      (clock),
		.reset_n    (reset_n),
		.sprite_go  (sprite_go),
		.base_x     (base_x),
		.base_y     (base_y),
		.scene_last (scene_last),
		.pix_valid  (pix_valid),
		.addr       (addr),
		.pix_x      (pix_x),
		.pix_y      (pix_y),
		.pix_last   (pix_last),
		.sprite_end (sprite_end)
	);

	sprite_rom u_rom (
		.clock        (clock),
		.addr         (addr),
		.sprite_we    (sprite_we),
		.sprite_waddr (sprite_waddr),
		.sprite_wdata (sprite_wdata),
		.rd_colour    (rd_colour)
	);

	plot_stage u_plot (
		.clock       (clock),
		.reset_n     (reset_n),
		.pix_valid   (pix_valid),
		.pix_x       (pix_x),
		.pix_y       (pix_y),
		.pix_last    (pix_last),
		.rd_colour   (rd_colour),
		.plot        (plot),
		.plot_x      (plot_x),
		.plot_y      (plot_y),
		.plot_colour (plot_colour),
		.scene_done  (scene_done)
	);

endmodule

// File: src/scene_sequencer.sv
`timescale 1ns/1ps
`include "scene_consts.svh"

module scene_sequencer (
	input  logic                clock,
	input  logic                reset_n,
	input  logic                draw_start,
	input  scene_pkg::coord_x_t enemy_x,
	input  logic                sprite_end,
	output logic                sprite_go,
	output scene_pkg::coord_x_t base_x,
	output scene_pkg::coord_y_t base_y,
	output logic                scene_last,
	output logic                busy
);
	import scene_pkg::*;

	// cleared by reset, set once the first scene has been drawn
	logic init_done;
	sprite_id_t cur_id;
	sprite_id_t next_id;
	coord_x_t next_x;
	coord_y_t next_y;
	// cycles left until the plot pipeline is empty
	logic [1:0] drain_cnt;
	logic scene_start;
	logic sprite_next;
	logic scene_end;
	logic load_sprite;

	assign scene_start = !busy && draw_start;
	assign sprite_next = (drain_cnt == 2'd0) && sprite_end && !scene_last;
	assign scene_end = (drain_cnt == 2'd0) && sprite_end && scene_last;
	assign load_sprite = scene_start || sprite_next;

	// sprite list, the update scene skips the player
	always_comb
	begin
		if (!busy)
			next_id = ENEMY;
		else
		begin
			case (cur_id)
				ENEMY: next_id = LEFT_HAND;
				LEFT_HAND: next_id = init_done ? RIGHT_HAND : PLAYER;
				default: next_id = RIGHT_HAND;
			endcase
		end
	end

	// placement lookup
	always_comb
	begin
		case (next_id)
			ENEMY:
			begin
				next_x = init_done ? enemy_x : coord_x_t'(`INIT_ENEMY_X);
				next_y = coord_y_t'(`ENEMY_Y);
			end
			LEFT_HAND:
			begin
				next_x = init_done ? coord_x_t'(`UPD_LEFT_X) : coord_x_t'(`INIT_LEFT_X);
				next_y = coord_y_t'(`HAND_ROW_Y);
			end
			PLAYER:
			begin
				next_x = coord_x_t'(`INIT_PLAYER_X);
				next_y = coord_y_t'(`HAND_ROW_Y);
			end
			default:
			begin
				next_x = init_done ? coord_x_t'(`UPD_RIGHT_X) : coord_x_t'(`INIT_RIGHT_X);
				next_y = coord_y_t'(`HAND_ROW_Y);
			end
		endcase
	end

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			busy <= 1'b0;
			sprite_go <= 1'b0;
			scene_last <= 1'b0;
			init_done <= 1'b0;
			drain_cnt <= 2'd0;
			cur_id <= ENEMY;
		end
		else
		begin
			sprite_go <= load_sprite;
			if (scene_start)
				busy <= 1'b1;
			if (load_sprite)
			begin
				cur_id <= next_id;
				scene_last <= (next_id == RIGHT_HAND);
			end
			if (scene_end)
			begin
				// two more cycles for the memory read and the plot register
				drain_cnt <= 2'd2;
				scene_last <= 1'b0;
				init_done <= 1'b1;
			end
			else if (drain_cnt != 2'd0)
			begin
				drain_cnt <= drain_cnt - 2'd1;
				if (drain_cnt == 2'd1)
					busy <= 1'b0;
			end
		end
	end

	// enemy_x is taken here, when the enemy sprite starts
	always_ff @(posedge clock)
	begin
		if (load_sprite)
		begin
			base_x <= next_x;
			base_y <= next_y;
		end
	end

	a_go_only_busy: assert property (@(posedge clock) disable iff (!reset_n)
		sprite_go |-> busy);

endmodule

// File: src/sprite_rom.sv
`timescale 1ns/1ps
`include "scene_consts.svh"

module sprite_rom (
	input  logic                    clock,
	input  scene_pkg::sprite_addr_t addr,
	input  logic                    sprite_we,
	input  scene_pkg::sprite_addr_t sprite_waddr,
	input  scene_pkg::colour_t      sprite_wdata,
	output scene_pkg::colour_t      rd_colour
);
	import scene_pkg::*;

	// one image shared by every sprite
	colour_t mem [0:`SPRITE_PIXELS-1];

	// loaded from outside between scenes
	always_ff @(posedge clock)
	begin
		if (sprite_we)
			mem[sprite_waddr] <= sprite_wdata;
	end

	// registered read, data one cycle after addr
	always_ff @(posedge clock)
	begin
		rd_colour <= mem[addr];
	end

endmodule

// File: src/sprite_scanner.sv
`timescale 1ns/1ps
`include "scene_consts.svh"

module sprite_scanner (
	input  logic                    clock,
	input  logic                    reset_n,
	input  logic                    sprite_go,
	input  scene_pkg::coord_x_t     base_x,
	input  scene_pkg::coord_y_t     base_y,
	input  logic                    scene_last,
	output logic                    pix_valid,
	output scene_pkg::sprite_addr_t addr,
	output scene_pkg::coord_x_t     pix_x,
	output scene_pkg::coord_y_t     pix_y,
	output logic                    pix_last,
	output logic                    sprite_end
);
	import scene_pkg::*;

	logic active;
	logic [5:0] col;
	logic [5:0] row;
	// base held for the whole sprite
	coord_x_t org_x;
	coord_y_t org_y;
	logic row_end;

	assign row_end = (col == 6'(`SPRITE_DIM - 1));
	assign sprite_end = active && row_end && (row == 6'(`SPRITE_DIM - 1));
	assign pix_last = sprite_end && scene_last;
	assign pix_valid = active;
	// x wraps modulo 256 by width
	assign pix_x = org_x + coord_x_t'(col);
	assign pix_y = org_y + coord_y_t'(row);

	always_ff @(posedge clock)
	begin
		if (!reset_n)
		begin
			active <= 1'b0;
			col <= 6'd0;
			row <= 6'd0;
			addr <= '0;
		end
		else if (!active)
		begin
			// new sprite only from idle
			if (sprite_go)
				active <= 1'b1;
			col <= 6'd0;
			row <= 6'd0;
			addr <= '0;
		end
		else
		begin
			addr <= addr + 1'b1;
			if (sprite_end)
				active <= 1'b0;
			if (row_end)
			begin
				col <= 6'd0;
				row <= row + 6'd1;
			end
			else
				col <= col + 6'd1;
		end
	end

	always_ff @(posedge clock)
	begin
		if (sprite_go && !active)
		begin
			org_x <= base_x;
			org_y <= base_y;
		end
	end

	a_addr_range: assert property (@(posedge clock) disable iff (!reset_n)
		pix_valid |-> (addr < sprite_addr_t'(`SPRITE_PIXELS)));

endmodule
